//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_he_accel
FILELIST  := he_accel.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- he_accel.f
rtl/he_bus_pkg.sv
rtl/he_cfg_pkg.sv
rtl/he_csr_axil.sv
rtl/he_seq_fsm.sv
rtl/he_dma_engine.sv
rtl/he_coeff_store.sv
rtl/he_mod_alu.sv
rtl/he_accel_top.sv
testbench/tb_mem_model.sv
testbench/tb_he_accel.sv

//--- rtl/he_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module he_accel_top
   import he_cfg_pkg::*;
   import he_bus_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  axil_aw_s  s_aw_i,
   output logic      s_awready_o,
   input  axil_w_s   s_w_i,
   output logic      s_wready_o,
   output logic      s_bvalid_o,
   input  logic      s_bready_i,
   input  axil_aw_s  s_ar_i,
   output logic      s_arready_o,
   output axil_r_s   s_r_o,
   input  logic      s_rready_i,
   output mem_req_s  mem_req_o,
   output logic      mem_req_valid_o,
   input  logic      mem_req_ready_i,
   input  mem_resp_s mem_resp_i,
   input  logic      mem_resp_valid_i,
   output logic      mem_resp_ready_o,
   output logic      irq_o
);

   he_cfg_s cfg;
   logic    csr_start;
   logic    csr_done;
   logic    busy;
   logic    done_set;
   logic    dma_start;
   ptr_t    dma_base;
   logic    dma_write;
   logic    dma_done;
   logic    alu_start;
   logic    alu_done;
   logic    load_sel_b;
   logic    ld_en;
   idx_t    ld_idx;
   coeff_t  ld_data;
   idx_t    wb_idx;
   coeff_t  wb_data;
   idx_t    rd_idx;
   coeff_t  rd_a;
   coeff_t  rd_b;
   logic    alu_w_en;
   idx_t    alu_w_idx;
   coeff_t  alu_w_data;

   he_csr_axil u_csr (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .s_aw_i      (s_aw_i),
      .s_awready_o (s_awready_o),
      .s_w_i       (s_w_i),
      .s_wready_o  (s_wready_o),
      .s_bvalid_o  (s_bvalid_o),
      .s_bready_i  (s_bready_i),
      .s_ar_i      (s_ar_i),
      .s_arready_o (s_arready_o),
      .s_r_o       (s_r_o),
      .s_rready_i  (s_rready_i),
      .busy_i      (busy),
      .done_set_i  (done_set),
      .cfg_o       (cfg),
      .start_o     (csr_start),
      .done_o      (csr_done)
   );

   he_seq_fsm u_seq (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (csr_start),
      .cfg_i        (cfg),
      .done_i       (csr_done),
      .dma_start_o  (dma_start),
      .dma_base_o   (dma_base),
      .dma_write_o  (dma_write),
      .dma_done_i   (dma_done),
      .alu_start_o  (alu_start),
      .alu_done_i   (alu_done),
      .load_sel_b_o (load_sel_b),
      .busy_o       (busy),
      .done_set_o   (done_set),
      .irq_o        (irq_o)
   );

   he_dma_engine u_dma (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .start_i          (dma_start),
      .base_i           (dma_base),
      .write_i          (dma_write),
      .log_n_i          (cfg.log_n),
      .mem_req_o        (mem_req_o),
      .mem_req_valid_o  (mem_req_valid_o),
      .mem_req_ready_i  (mem_req_ready_i),
      .mem_resp_i       (mem_resp_i),
      .mem_resp_valid_i (mem_resp_valid_i),
      .mem_resp_ready_o (mem_resp_ready_o),
      .ld_en_o          (ld_en),
      .ld_idx_o         (ld_idx),
      .ld_data_o        (ld_data),
      .wb_idx_o         (wb_idx),
      .wb_data_i        (wb_data),
      .done_o           (dma_done)
   );

   he_coeff_store u_store (
      .clk_i        (clk_i),
      .ld_en_i      (ld_en),
      .ld_sel_b_i   (load_sel_b),
      .ld_idx_i     (ld_idx),
      .ld_data_i    (ld_data),
      .log_n_i      (cfg.log_n),
      .rd_idx_i     (rd_idx),
      .rd_a_o       (rd_a),
      .rd_b_o       (rd_b),
      .alu_w_en_i   (alu_w_en),
      .alu_w_idx_i  (alu_w_idx),
      .alu_w_data_i (alu_w_data),
      .wb_idx_i     (wb_idx),
      .wb_data_o    (wb_data)
   );

   he_mod_alu u_alu (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .start_i  (alu_start),
      .log_n_i  (cfg.log_n),
      .q_i      (cfg.q),
      .op_sub_i (cfg.op_sub),
      .rd_idx_o (rd_idx),
      .rd_a_i   (rd_a),
      .rd_b_i   (rd_b),
      .w_en_o   (alu_w_en),
      .w_idx_o  (alu_w_idx),
      .w_data_o (alu_w_data),
      .done_o   (alu_done)
   );

endmodule

`default_nettype wire

//--- rtl/he_bus_pkg.sv
`default_nettype none

package he_bus_pkg;

   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;
   localparam int STRB_WIDTH = DATA_WIDTH / 8;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   ////////////////////
   // AXI4-Lite host channels
   // the address struct serves both AW and AR
   typedef struct packed {
      logic                  valid;
      logic [ADDR_WIDTH-1:0] addr;
   } axil_aw_s;

   typedef struct packed {
      logic                  valid;
      logic [DATA_WIDTH-1:0] data;
      logic [STRB_WIDTH-1:0] strb;
   } axil_w_s;

   typedef struct packed {
      logic                  valid;
      logic [DATA_WIDTH-1:0] data;
      logic [1:0]            resp;
   } axil_r_s;

   ////////////////////
   // memory side, one word per request
   typedef struct packed {
      logic                  write;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] wdata;
   } mem_req_s;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] rdata;
   } mem_resp_s;

endpackage

`default_nettype wire

//--- rtl/he_cfg_pkg.sv
`default_nettype none

package he_cfg_pkg;
   import he_bus_pkg::*;

   // bank sizing, banks hold up to 2**MAX_LOG_N coefficients
   localparam int MAX_LOG_N = 8;
   localparam int MAX_N     = 1 << MAX_LOG_N;
   localparam int Q_WIDTH   = 30;
   localparam int LOG_N_W   = $clog2(MAX_LOG_N + 1);

   typedef logic [Q_WIDTH-1:0]    coeff_t;
   typedef logic [MAX_LOG_N-1:0]  idx_t;
   typedef logic [LOG_N_W-1:0]    log_n_t;
   typedef logic [ADDR_WIDTH-1:0] ptr_t;

   ////////////////////
   // register map, byte offsets within the CSR window
   typedef logic [7:0] csr_off_t;

   localparam csr_off_t CSR_CTRL   = 8'h00;
   localparam csr_off_t CSR_STATUS = 8'h04;
   localparam csr_off_t CSR_LOG_N  = 8'h08;
   localparam csr_off_t CSR_Q      = 8'h0C;
   localparam csr_off_t CSR_A_PTR  = 8'h10;
   localparam csr_off_t CSR_B_PTR  = 8'h14;
   localparam csr_off_t CSR_WB_PTR = 8'h18;

   typedef struct packed {
      log_n_t log_n;
      coeff_t q;
      logic   op_sub;
      ptr_t   a_ptr;
      ptr_t   b_ptr;
      ptr_t   wb_ptr;
   } he_cfg_s;

   typedef enum logic [2:0] {
      IDLE,
      LOAD_A,
      LOAD_B,
      COMPUTE,
      WRITE_BACK,
      DONE
   } seq_phase_e;

   // index of the last element, n - 1
   function automatic idx_t last_index(log_n_t log_n);
      logic [MAX_LOG_N:0] n;
      n = {{MAX_LOG_N{1'b0}}, 1'b1} << log_n;
      return idx_t'(n - 1'b1);
   endfunction

endpackage

`default_nettype wire

//--- rtl/he_coeff_store.sv
`timescale 1ns/1ps
`default_nettype none

module he_coeff_store
   import he_cfg_pkg::*;
(
   input  logic   clk_i,
   input  logic   ld_en_i,
   input  logic   ld_sel_b_i,
   input  idx_t   ld_idx_i,
   input  coeff_t ld_data_i,
   input  log_n_t log_n_i,
   input  idx_t   rd_idx_i,
   output coeff_t rd_a_o,
   output coeff_t rd_b_o,
   input  logic   alu_w_en_i,
   input  idx_t   alu_w_idx_i,
   input  coeff_t alu_w_data_i,
   input  idx_t   wb_idx_i,
   output coeff_t wb_data_o
);

   coeff_t bank_a [MAX_N];
   coeff_t bank_b [MAX_N];
   logic   a_we;
   idx_t   a_widx;
   coeff_t a_wdata;

   // reverse the low log_n bits of an element index
   function automatic idx_t bit_rev(idx_t idx, log_n_t log_n);
      idx_t rev;
      rev = {<<{idx}};
      return rev >> (MAX_LOG_N - int'(log_n));
   endfunction

   // loads and ALU results never overlap, so bank A has one write port
   always_comb
   begin
      a_we    = alu_w_en_i || (ld_en_i && !ld_sel_b_i);
      a_widx  = alu_w_en_i ? alu_w_idx_i : bit_rev(ld_idx_i, log_n_i);
      a_wdata = alu_w_en_i ? alu_w_data_i : ld_data_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (a_we)
         bank_a[a_widx] <= a_wdata;
      if (ld_en_i && ld_sel_b_i)
         bank_b[bit_rev(ld_idx_i, log_n_i)] <= ld_data_i;

      rd_a_o    <= bank_a[rd_idx_i];
      rd_b_o    <= bank_b[rd_idx_i];
      // undo the load reversal so memory sees natural order
      wb_data_o <= bank_a[bit_rev(wb_idx_i, log_n_i)];
   end

endmodule

`default_nettype wire

//--- rtl/he_csr_axil.sv
`timescale 1ns/1ps
`default_nettype none

module he_csr_axil
   import he_cfg_pkg::*;
   import he_bus_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  axil_aw_s s_aw_i,
   output logic     s_awready_o,
   input  axil_w_s  s_w_i,
   output logic     s_wready_o,
   output logic     s_bvalid_o,
   input  logic     s_bready_i,
   input  axil_aw_s s_ar_i,
   output logic     s_arready_o,
   output axil_r_s  s_r_o,
   input  logic     s_rready_i,
   input  logic     busy_i,
   input  logic     done_set_i,
   output he_cfg_s  cfg_o,
   output logic     start_o,
   output logic     done_o
);

   he_cfg_s               cfg_r;
   axil_r_s               r_r;
   logic                  done_r;
   logic                  start_r;
   logic                  bvalid_r;
   logic                  wr_fire;
   logic                  rd_fire;
   logic                  done_clr;
   logic [DATA_WIDTH:0]   wr_cur;
   logic [DATA_WIDTH:0]   rd_cur;
   logic [DATA_WIDTH-1:0] wr_mask;
   logic [DATA_WIDTH-1:0] wr_val;

   // top bit marks a mapped offset, unmapped reads give zero data
   function automatic logic [DATA_WIDTH:0] csr_read(csr_off_t off);
      case (off)
         CSR_CTRL:   return {1'b1, DATA_WIDTH'({cfg_r.op_sub, 1'b0})};
         CSR_STATUS: return {1'b1, DATA_WIDTH'({done_r, busy_i})};
         CSR_LOG_N:  return {1'b1, DATA_WIDTH'(cfg_r.log_n)};
         CSR_Q:      return {1'b1, DATA_WIDTH'(cfg_r.q)};
         CSR_A_PTR:  return {1'b1, cfg_r.a_ptr};
         CSR_B_PTR:  return {1'b1, cfg_r.b_ptr};
         CSR_WB_PTR: return {1'b1, cfg_r.wb_ptr};
         default:    return '0;
      endcase
   endfunction

   always_comb
   begin
      wr_fire = s_aw_i.valid && s_w_i.valid && !bvalid_r;
      rd_fire = s_ar_i.valid && !r_r.valid;
      wr_cur  = csr_read(s_aw_i.addr[7:0]);
      rd_cur  = csr_read(s_ar_i.addr[7:0]);
      for (int i = 0; i < STRB_WIDTH; i++)
      begin
         wr_mask[i*8 +: 8] = {8{s_w_i.strb[i]}};
      end
      // byte lanes without a strobe keep their old contents
      wr_val   = (wr_cur[DATA_WIDTH-1:0] & ~wr_mask) | (s_w_i.data & wr_mask);
      done_clr = wr_fire && (s_aw_i.addr[7:0] == CSR_STATUS)
                 && s_w_i.strb[0] && s_w_i.data[1];
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         cfg_r    <= '0;
         r_r      <= '0;
         done_r   <= 1'b0;
         start_r  <= 1'b0;
         bvalid_r <= 1'b0;
      end
      else
      begin
         start_r <= 1'b0;
         if (wr_fire && wr_cur[DATA_WIDTH])
         begin
            case (s_aw_i.addr[7:0])
               CSR_CTRL:
               begin
                  cfg_r.op_sub <= wr_val[1];
                  // start only lands when the sequencer is free
                  start_r      <= wr_val[0] && !busy_i;
               end
               CSR_LOG_N:
                  cfg_r.log_n <= (wr_val > MAX_LOG_N) ? log_n_t'(MAX_LOG_N) : log_n_t'(wr_val);
               CSR_Q:      cfg_r.q      <= coeff_t'(wr_val);
               CSR_A_PTR:  cfg_r.a_ptr  <= wr_val;
               CSR_B_PTR:  cfg_r.b_ptr  <= wr_val;
               CSR_WB_PTR: cfg_r.wb_ptr <= wr_val;
               default:    ;
            endcase
         end

         // sticky done, a finishing run wins over a clear in the same cycle
         if (done_set_i)
            done_r <= 1'b1;
         else if (done_clr || start_r)
            done_r <= 1'b0;

         if (wr_fire)
            bvalid_r <= 1'b1;
         else if (s_bready_i)
            bvalid_r <= 1'b0;

         if (rd_fire)
         begin
            r_r.valid <= 1'b1;
            r_r.data  <= rd_cur[DATA_WIDTH-1:0];
            r_r.resp  <= rd_cur[DATA_WIDTH] ? RESP_OKAY : RESP_SLVERR;
         end
         else if (s_rready_i)
            r_r.valid <= 1'b0;
      end
   end

   assign s_awready_o = wr_fire;
   assign s_wready_o  = wr_fire;
   assign s_bvalid_o  = bvalid_r;
   assign s_arready_o = !r_r.valid;
   assign s_r_o       = r_r;
   assign cfg_o       = cfg_r;
   assign start_o     = start_r;
   assign done_o      = done_r;

   a_bvalid_after_write: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(bvalid_r) |-> $past(wr_fire));

endmodule

`default_nettype wire

//--- rtl/he_dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

module he_dma_engine
   import he_cfg_pkg::*;
   import he_bus_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      start_i,
   input  ptr_t      base_i,
   input  logic      write_i,
   input  log_n_t    log_n_i,
   output mem_req_s  mem_req_o,
   output logic      mem_req_valid_o,
   input  logic      mem_req_ready_i,
   input  mem_resp_s mem_resp_i,
   input  logic      mem_resp_valid_i,
   output logic      mem_resp_ready_o,
   output logic      ld_en_o,
   output idx_t      ld_idx_o,
   output coeff_t    ld_data_o,
   output idx_t      wb_idx_o,
   input  coeff_t    wb_data_i,
   output logic      done_o
);

   typedef enum logic [1:0] {
      D_IDLE,
      D_SETUP,
      D_REQ,
      D_RESP
   } dma_state_e;

   dma_state_e state_r;
   idx_t       idx_r;
   ptr_t       base_r;
   logic       write_r;
   logic       last;
   logic       resp_fire;

   assign last      = (idx_r == last_index(log_n_i));
   assign resp_fire = (state_r == D_RESP) && mem_resp_valid_i;

   ////////////////////
   // element loop: setup, request, response
   // setup gives the store a cycle to return the write-back word
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= D_IDLE;
         idx_r   <= '0;
      end
      else
      begin
         case (state_r)
            D_IDLE:
            begin
               if (start_i)
               begin
                  idx_r   <= '0;
                  state_r <= D_SETUP;
               end
            end
            D_SETUP: state_r <= D_REQ;
            D_REQ:   if (mem_req_ready_i) state_r <= D_RESP;
            D_RESP:
            begin
               if (mem_resp_valid_i)
               begin
                  idx_r   <= idx_r + 1'b1;
                  state_r <= last ? D_IDLE : D_SETUP;
               end
            end
            default: state_r <= D_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (start_i && (state_r == D_IDLE))
      begin
         base_r  <= base_i;
         write_r <= write_i;
      end
   end

   // the store holds wb_data_i while idx_r is unchanged
   always_comb
   begin
      mem_req_o.write = write_r;
      mem_req_o.addr  = base_r + ADDR_WIDTH'({idx_r, 2'b00});
      mem_req_o.wdata = DATA_WIDTH'(wb_data_i);
   end

   assign mem_req_valid_o  = (state_r == D_REQ);
   assign mem_resp_ready_o = 1'b1;
   assign ld_en_o          = resp_fire && !write_r;
   assign ld_idx_o         = idx_r;
   assign ld_data_o        = mem_resp_i.rdata[Q_WIDTH-1:0];
   assign wb_idx_o         = idx_r;
   assign done_o           = resp_fire && last;

   a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

`default_nettype wire

//--- rtl/he_mod_alu.sv
`timescale 1ns/1ps
`default_nettype none

module he_mod_alu
   import he_cfg_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,
   input  logic   start_i,
   input  log_n_t log_n_i,
   input  coeff_t q_i,
   input  logic   op_sub_i,
   output idx_t   rd_idx_o,
   input  coeff_t rd_a_i,
   input  coeff_t rd_b_i,
   output logic   w_en_o,
   output idx_t   w_idx_o,
   output coeff_t w_data_o,
   output logic   done_o
);

   logic             run_r;
   logic             v1_r;
   logic             last1_r;
   logic             done_r;
   logic             last_issue;
   idx_t             idx_r;
   idx_t             idx1_r;
   logic [Q_WIDTH:0] sum;
   logic [Q_WIDTH:0] diff;
   coeff_t           res;

   assign last_issue = run_r && (idx_r == last_index(log_n_i));

   ////////////////////
   // stage 1 issues one index per cycle to both banks
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         run_r   <= 1'b0;
         v1_r    <= 1'b0;
         last1_r <= 1'b0;
         done_r  <= 1'b0;
         idx_r   <= '0;
      end
      else
      begin
         if (start_i)
         begin
            run_r <= 1'b1;
            idx_r <= '0;
         end
         else if (run_r)
         begin
            idx_r <= idx_r + 1'b1;
            if (last_issue)
               run_r <= 1'b0;
         end
         v1_r    <= run_r;
         last1_r <= last_issue;
         done_r  <= v1_r && last1_r;
      end
   end

   always_ff @(posedge clk_i)
   begin
      idx1_r <= idx_r;
   end

   ////////////////////
   // stage 2, one correction step brings the result into [0, q)
   always_comb
   begin
      sum  = {1'b0, rd_a_i} + {1'b0, rd_b_i};
      diff = {1'b0, rd_a_i} - {1'b0, rd_b_i};
      if (op_sub_i)
         // borrow out means a < b, wrap by adding q
         res = diff[Q_WIDTH] ? coeff_t'(diff + {1'b0, q_i}) : coeff_t'(diff);
      else
         res = (sum >= {1'b0, q_i}) ? coeff_t'(sum - {1'b0, q_i}) : coeff_t'(sum);
   end

   assign rd_idx_o = idx_r;
   assign w_en_o   = v1_r;
   assign w_idx_o  = idx1_r;
   assign w_data_o = res;
   assign done_o   = done_r;

   a_result_reduced: assert property (@(posedge clk_i) disable iff (reset_i)
      w_en_o |-> (w_data_o < q_i));

endmodule

`default_nettype wire

//--- rtl/he_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module he_seq_fsm
   import he_cfg_pkg::*;
(
   input  logic    clk_i,
   input  logic    reset_i,
   input  logic    start_i,
   input  he_cfg_s cfg_i,
   input  logic    done_i,
   output logic    dma_start_o,
   output ptr_t    dma_base_o,
   output logic    dma_write_o,
   input  logic    dma_done_i,
   output logic    alu_start_o,
   input  logic    alu_done_i,
   output logic    load_sel_b_o,
   output logic    busy_o,
   output logic    done_set_o,
   output logic    irq_o
);

   seq_phase_e phase_r;
   seq_phase_e phase_n;
   logic       dma_start_r;
   logic       alu_start_r;

   always_comb
   begin
      phase_n = phase_r;
      case (phase_r)
         IDLE:       if (start_i) phase_n = LOAD_A;
         LOAD_A:     if (dma_done_i) phase_n = LOAD_B;
         LOAD_B:     if (dma_done_i) phase_n = COMPUTE;
         COMPUTE:    if (alu_done_i) phase_n = WRITE_BACK;
         WRITE_BACK: if (dma_done_i) phase_n = DONE;
         DONE:
         begin
            // stay here, irq up, until the host clears done or starts again
            if (start_i)
               phase_n = LOAD_A;
            else if (!done_i)
               phase_n = IDLE;
         end
         default:    phase_n = IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         phase_r     <= IDLE;
         dma_start_r <= 1'b0;
         alu_start_r <= 1'b0;
      end
      else
      begin
         phase_r     <= phase_n;
         dma_start_r <= (phase_n != phase_r) && (phase_n inside {LOAD_A, LOAD_B, WRITE_BACK});
         alu_start_r <= (phase_n != phase_r) && (phase_n == COMPUTE);
      end
   end

   // pointer for whichever DMA pass is running
   always_comb
   begin
      case (phase_r)
         LOAD_A:  dma_base_o = cfg_i.a_ptr;
         LOAD_B:  dma_base_o = cfg_i.b_ptr;
         default: dma_base_o = cfg_i.wb_ptr;
      endcase
   end

   assign dma_start_o  = dma_start_r;
   assign alu_start_o  = alu_start_r;
   assign dma_write_o  = (phase_r == WRITE_BACK);
   assign load_sel_b_o = (phase_r == LOAD_B);
   assign busy_o       = !(phase_r inside {IDLE, DONE});
   assign done_set_o   = (phase_r == WRITE_BACK) && dma_done_i;
   assign irq_o        = (phase_r == DONE);

endmodule

`default_nettype wire

//--- testbench/tb_he_accel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_he_accel
   import he_cfg_pkg::*;
   import he_bus_pkg::*;
();

   localparam int SEED            = 32'h215;
   localparam int MEM_WORDS       = 4096;
   // elements over all three runs (log_n 4, 8 and 6)
   localparam int RUN_ELEMS       = 16 + 256 + 64;
   localparam int WATCHDOG_CYCLES = 60 * RUN_ELEMS + 2000;

   logic        clk_i;
   logic        reset_i;
   axil_aw_s    aw;
   axil_w_s     w;
   axil_aw_s    ar;
   axil_r_s     r;
   logic        awready;
   logic        wready;
   logic        bvalid;
   logic        bready;
   logic        arready;
   logic        rready;
   mem_req_s    mem_req;
   mem_resp_s   mem_resp;
   logic [31:0] mem_rdata;
   logic        mem_req_valid;
   logic        mem_req_ready;
   logic        mem_resp_valid;
   logic        mem_resp_ready;
   logic        irq;

   // expected state of the current run
   logic [31:0] a_vals [MAX_N];
   logic [31:0] b_vals [MAX_N];
   logic [31:0] exp_vals [MAX_N];
   logic [31:0] shadow [MEM_WORDS];
   logic [31:0] cur_wb;
   int          cur_n;
   int          write_count;

   he_accel_top u_dut (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .s_aw_i           (aw),
      .s_awready_o      (awready),
      .s_w_i            (w),
      .s_wready_o       (wready),
      .s_bvalid_o       (bvalid),
      .s_bready_i       (bready),
      .s_ar_i           (ar),
      .s_arready_o      (arready),
      .s_r_o            (r),
      .s_rready_i       (rready),
      .mem_req_o        (mem_req),
      .mem_req_valid_o  (mem_req_valid),
      .mem_req_ready_i  (mem_req_ready),
      .mem_resp_i       (mem_resp),
      .mem_resp_valid_i (mem_resp_valid),
      .mem_resp_ready_o (mem_resp_ready),
      .irq_o            (irq)
   );

   tb_mem_model #(.WORDS(MEM_WORDS)) u_mem (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_valid_i  (mem_req_valid),
      .req_ready_o  (mem_req_ready),
      .req_write_i  (mem_req.write),
      .req_addr_i   (mem_req.addr),
      .req_wdata_i  (mem_req.wdata),
      .resp_valid_o (mem_resp_valid),
      .resp_rdata_o (mem_rdata),
      .resp_ready_i (mem_resp_ready)
   );

   assign mem_resp.rdata = mem_rdata;

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   ////////////////////
   // checking helpers
   task automatic stop_on_error();
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH time=%0t signal=%s got=0x%08h expected=0x%08h",
                  $time, name, got, exp);
         stop_on_error();
      end
   endtask

   // (a + b) mod q or (a - b) mod q in 64 bits so nothing wraps
   function automatic logic [31:0] mod_ref(input logic [31:0] a, input logic [31:0] b,
                                           input logic [31:0] q, input logic sub);
      longint unsigned la;
      longint unsigned lb;
      longint unsigned lq;
      la = 64'(a);
      lb = 64'(b);
      lq = 64'(q);
      if (sub)
         return 32'((la + lq - lb) % lq);
      else
         return 32'((la + lb) % lq);
   endfunction

   ////////////////////
   // host side AXI4-Lite accesses
   task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk_i);
      aw.valid <= 1'b1;
      aw.addr  <= addr;
      w.valid  <= 1'b1;
      w.data   <= data;
      w.strb   <= 4'hF;
      do
         @(negedge clk_i);
      while (!(awready && wready));
      @(posedge clk_i);
      aw.valid <= 1'b0;
      w.valid  <= 1'b0;
      bready   <= 1'b1;
      do
         @(negedge clk_i);
      while (!bvalid);
      @(posedge clk_i);
      bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      @(posedge clk_i);
      ar.valid <= 1'b1;
      ar.addr  <= addr;
      do
         @(negedge clk_i);
      while (!arready);
      @(posedge clk_i);
      ar.valid <= 1'b0;
      rready   <= 1'b1;
      do
         @(negedge clk_i);
      while (!r.valid);
      data = r.data;
      resp = r.resp;
      @(posedge clk_i);
      rready <= 1'b0;
   endtask

   task automatic csr_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] exp);
      logic [31:0] data;
      logic [1:0]  resp;
      axil_read(addr, data, resp);
      check_value({name, ".resp"}, {30'd0, resp}, {30'd0, RESP_OKAY});
      check_value(name, data, exp);
   endtask

   // result area holds the expected words and all other words are as before the run
   task automatic verify_memory(input logic [31:0] wb_ptr, input int n);
      int wb_w;
      wb_w = int'(wb_ptr >> 2);
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         if (i >= wb_w && i < wb_w + n)
            check_value($sformatf("mem[%0d]", i), u_mem.mem[i], exp_vals[i - wb_w]);
         else
            check_value($sformatf("mem[%0d]", i), u_mem.mem[i], shadow[i]);
      end
   endtask

   task automatic run_job(input int log_n, input logic op_sub, input logic [31:0] a_ptr,
                          input logic [31:0] b_ptr, input logic [31:0] wb_ptr);
      logic [31:0] q;
      int          n;
      int          a_w;
      int          b_w;
      n   = 1 << log_n;
      a_w = int'(a_ptr >> 2);
      b_w = int'(b_ptr >> 2);
      // q in the upper half of the 30 bit range so sums cross 2**30
      q   = 32'h2000_0000 | ($urandom & 32'h1FFF_FFFF);
      for (int i = 0; i < n; i++)
      begin
         a_vals[i] = $urandom % q;
         b_vals[i] = $urandom % q;
      end
      a_vals[0]   = 32'd0;
      b_vals[0]   = q - 1;
      a_vals[n-1] = q - 1;
      b_vals[n-1] = q - 1;
      for (int i = 0; i < n; i++)
      begin
         u_mem.mem[a_w + i] = a_vals[i];
         u_mem.mem[b_w + i] = b_vals[i];
         exp_vals[i]        = mod_ref(a_vals[i], b_vals[i], q, op_sub);
      end
      for (int i = 0; i < MEM_WORDS; i++)
         shadow[i] = u_mem.mem[i];
      cur_wb      = wb_ptr;
      cur_n       = n;
      write_count = 0;

      axil_write(32'(CSR_LOG_N), 32'(log_n));
      axil_write(32'(CSR_Q), q);
      axil_write(32'(CSR_A_PTR), a_ptr);
      axil_write(32'(CSR_B_PTR), b_ptr);
      axil_write(32'(CSR_WB_PTR), wb_ptr);
      axil_write(32'(CSR_CTRL), {30'd0, op_sub, 1'b1});
      csr_expect("STATUS while running", 32'(CSR_STATUS), 32'h1);

      do
         @(negedge clk_i);
      while (!irq);
      check_value("write-back count", 32'(write_count), 32'(n));
      csr_expect("STATUS after run", 32'(CSR_STATUS), 32'h2);
      repeat (8) @(negedge clk_i);
      check_value("irq_o held", {31'd0, irq}, 32'd1);

      // write 1 to the done bit
      axil_write(32'(CSR_STATUS), 32'h2);
      repeat (2) @(negedge clk_i);
      check_value("irq_o after clear", {31'd0, irq}, 32'd0);
      csr_expect("STATUS after clear", 32'(CSR_STATUS), 32'h0);
      verify_memory(wb_ptr, n);
   endtask

   ////////////////////
   // results must reach memory in natural order
   always @(negedge clk_i)
   begin
      if (mem_req_valid && mem_req_ready && mem_req.write)
      begin
         if (write_count >= cur_n)
         begin
            $display("more write-backs than elements in the run");
            stop_on_error();
         end
         check_value("mem_req_o.addr", mem_req.addr, cur_wb + 32'(write_count * 4));
         check_value("mem_req_o.wdata", mem_req.wdata, exp_vals[write_count]);
         write_count++;
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
      stop_on_error();
   end

   initial
   begin
      logic [31:0] rdata;
      logic [1:0]  rresp;
      void'($urandom(SEED));
      reset_i     = 1'b1;
      aw          = '0;
      w           = '0;
      ar          = '0;
      bready      = 1'b0;
      rready      = 1'b0;
      cur_wb      = '0;
      cur_n       = 0;
      write_count = 0;
      repeat (2) @(posedge clk_i);
      reset_i <= 1'b0;
      @(posedge clk_i);

      // register readback
      axil_write(32'(CSR_LOG_N), 32'd5);
      axil_write(32'(CSR_Q), 32'h1234_5677);
      axil_write(32'(CSR_A_PTR), 32'hDEAD_BEE0);
      axil_write(32'(CSR_B_PTR), 32'h0BAD_F00C);
      axil_write(32'(CSR_WB_PTR), 32'h0000_1234);
      axil_write(32'(CSR_CTRL), 32'h2);
      csr_expect("LOG_N", 32'(CSR_LOG_N), 32'd5);
      csr_expect("Q", 32'(CSR_Q), 32'h1234_5677);
      csr_expect("A_PTR", 32'(CSR_A_PTR), 32'hDEAD_BEE0);
      csr_expect("B_PTR", 32'(CSR_B_PTR), 32'h0BAD_F00C);
      csr_expect("WB_PTR", 32'(CSR_WB_PTR), 32'h0000_1234);
      csr_expect("CTRL", 32'(CSR_CTRL), 32'h2);
      csr_expect("STATUS idle", 32'(CSR_STATUS), 32'h0);
      axil_read(32'h0000_0020, rdata, rresp);
      check_value("unmapped.resp", {30'd0, rresp}, {30'd0, RESP_SLVERR});
      check_value("unmapped.data", rdata, 32'h0);

      run_job(4, 1'b0, 32'h0000_0000, 32'h0000_0400, 32'h0000_0800);
      run_job(8, 1'b1, 32'h0000_1000, 32'h0000_1400, 32'h0000_1800);
      // restart without reset with new pointers and q
      run_job(6, 1'b0, 32'h0000_2000, 32'h0000_2400, 32'h0000_2800);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
#(
   parameter int WORDS = 4096
)
(
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic        req_valid_i,
   output logic        req_ready_o,
   input  logic        req_write_i,
   input  logic [31:0] req_addr_i,
   input  logic [31:0] req_wdata_i,
   output logic        resp_valid_o,
   output logic [31:0] resp_rdata_o,
   input  logic        resp_ready_i
);

   localparam int AW = $clog2(WORDS);

   logic [31:0]   mem [WORDS];
   logic          ready_r = 1'b0;
   logic          rvalid_r = 1'b0;
   logic [31:0]   rdata_r = '0;
   logic          pending;
   logic [AW-1:0] req_word;
   int            accept_wait;
   int            resp_wait;

   // background pattern, every word address gets its own value
   initial
   begin
      for (int i = 0; i < WORDS; i++)
         mem[i] = (i * 32'h9E37_79B9) ^ 32'h5A00_0000;
   end

   ////////////////////
   // one request at a time: wait, accept, wait, answer
   always @(posedge clk_i)
   begin
      if (reset_i)
      begin
         ready_r     <= 1'b0;
         rvalid_r    <= 1'b0;
         rdata_r     <= '0;
         pending     <= 1'b0;
         accept_wait <= $urandom_range(3, 0);
         resp_wait   <= 0;
      end
      else if (req_valid_i && ready_r)
      begin
         ready_r   <= 1'b0;
         pending   <= 1'b1;
         req_word  <= req_addr_i[AW+1:2];
         resp_wait <= $urandom_range(3, 0);
         if (req_write_i)
            mem[req_addr_i[AW+1:2]] <= req_wdata_i;
      end
      else if (pending)
      begin
         if (rvalid_r)
         begin
            if (resp_ready_i)
            begin
               rvalid_r    <= 1'b0;
               pending     <= 1'b0;
               accept_wait <= $urandom_range(3, 0);
            end
         end
         else if (resp_wait == 0)
         begin
            rvalid_r <= 1'b1;
            rdata_r  <= mem[req_word];
         end
         else
            resp_wait <= resp_wait - 1;
      end
      else if (req_valid_i)
      begin
         if (accept_wait == 0)
            ready_r <= 1'b1;
         else
            accept_wait <= accept_wait - 1;
      end
   end

   assign req_ready_o  = ready_r;
   assign resp_valid_o = rvalid_r;
   assign resp_rdata_o = rdata_r;

endmodule

`default_nettype wire
